//--- Bender.yml
package:
  name: vi_exe_core

sources:
  - source/vi_pkg.sv
  - source/vi_result_if.sv
  - source/vi_int_registers.sv
  - source/vi_issue.sv
  - source/vi_int_alu.sv
  - source/vi_mult_pipe.sv
  - source/vi_write_back.sv
  - source/vi_exe_core.sv
  - target: test
    files:
      - test/tb_vi_exe_core.sv

//--- list.f
source/vi_pkg.sv
source/vi_result_if.sv
source/vi_int_registers.sv
source/vi_issue.sv
source/vi_int_alu.sv
source/vi_mult_pipe.sv
source/vi_write_back.sv
source/vi_exe_core.sv
test/tb_vi_exe_core.sv

//--- source/vi_exe_core.sv
// Execute and write-back core top level: issue, register file, ALU, multiply, write-back
`timescale 1ns/1ps

module vi_exe_core #(
	parameter int unsigned MULT_STAGES = vi_pkg::MULT_STAGES_DEFAULT
) (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic              issue_valid_i,
	input  vi_pkg::xlen_t     issue_instr_i,
	input  vi_pkg::xlen_t     issue_pc_i,
	output logic              issue_stall_o,
	output logic              retire_valid_o,
	output vi_pkg::xlen_t     retire_pc_o,
	output vi_pkg::reg_addr_t retire_rd_o,
	output vi_pkg::xlen_t     retire_data_o,
	output logic              retire_illegal_o
);

	vi_pkg::reg_addr_t      rf_raddr_a;
	vi_pkg::reg_addr_t      rf_raddr_b;
	vi_pkg::xlen_t          rf_rdata_a;
	vi_pkg::xlen_t          rf_rdata_b;
	logic                   rf_we;
	vi_pkg::reg_addr_t      rf_waddr;
	vi_pkg::xlen_t          rf_wdata;

	// Issue to the execution paths
	logic                   alu_go;
	logic                   mul_go;
	vi_pkg::alu_op_e        ex_op;
	vi_pkg::xlen_t          ex_operand_a;
	vi_pkg::xlen_t          ex_operand_b;
	vi_pkg::reg_addr_t      ex_rd;
	vi_pkg::xlen_t          ex_pc;
	logic                   ex_illegal;

	// In-flight destinations back to issue
	logic                   alu_busy;
	vi_pkg::reg_addr_t      alu_rd;
	logic [MULT_STAGES-1:0] mul_busy;
	vi_pkg::reg_addr_t      mul_rd [MULT_STAGES];

	vi_result_if alu_res ();
	vi_result_if mul_res ();

	vi_issue #(
		.MULT_STAGES (MULT_STAGES)
	) u_issue (
		.issue_valid_i (issue_valid_i),
		.issue_instr_i (issue_instr_i),
		.issue_pc_i    (issue_pc_i),
		.read_addr_a_o (rf_raddr_a),
		.read_addr_b_o (rf_raddr_b),
		.read_data_a_i (rf_rdata_a),
		.read_data_b_i (rf_rdata_b),
		.alu_busy_i    (alu_busy),
		.alu_rd_i      (alu_rd),
		.mul_busy_i    (mul_busy),
		.mul_rd_i      (mul_rd),
		.issue_stall_o (issue_stall_o),
		.alu_go_o      (alu_go),
		.mul_go_o      (mul_go),
		.op_o          (ex_op),
		.operand_a_o   (ex_operand_a),
		.operand_b_o   (ex_operand_b),
		.rd_o          (ex_rd),
		.pc_o          (ex_pc),
		.illegal_o     (ex_illegal)
	);

	vi_int_registers u_int_registers (
		.clk_i          (clk_i),
		.rst_n_i        (rst_n_i),
		.read_addr_a_i  (rf_raddr_a),
		.read_addr_b_i  (rf_raddr_b),
		.read_data_a_o  (rf_rdata_a),
		.read_data_b_o  (rf_rdata_b),
		.write_enable_i (rf_we),
		.write_addr_i   (rf_waddr),
		.write_data_i   (rf_wdata)
	);

	vi_int_alu u_int_alu (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.go_i        (alu_go),
		.op_i        (ex_op),
		.operand_a_i (ex_operand_a),
		.operand_b_i (ex_operand_b),
		.rd_i        (ex_rd),
		.pc_i        (ex_pc),
		.illegal_i   (ex_illegal),
		.busy_o      (alu_busy),
		.rd_o        (alu_rd),
		.res         (alu_res.producer)
	);

	vi_mult_pipe #(
		.MULT_STAGES (MULT_STAGES)
	) u_mult_pipe (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.go_i        (mul_go),
		.operand_a_i (ex_operand_a),
		.operand_b_i (ex_operand_b),
		.rd_i        (ex_rd),
		.pc_i        (ex_pc),
		.busy_o      (mul_busy),
		.rd_o        (mul_rd),
		.res         (mul_res.producer)
	);

	vi_write_back u_write_back (
		.clk_i            (clk_i),
		.rst_n_i          (rst_n_i),
		.alu_res          (alu_res.consumer),
		.mul_res          (mul_res.consumer),
		.reg_we_o         (rf_we),
		.reg_waddr_o      (rf_waddr),
		.reg_wdata_o      (rf_wdata),
		.retire_valid_o   (retire_valid_o),
		.retire_pc_o      (retire_pc_o),
		.retire_rd_o      (retire_rd_o),
		.retire_data_o    (retire_data_o),
		.retire_illegal_o (retire_illegal_o)
	);

endmodule

//--- source/vi_int_alu.sv
// Single-stage integer ALU with registered result and illegal flag
`timescale 1ns/1ps

module vi_int_alu (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic              go_i,
	input  vi_pkg::alu_op_e   op_i,
	input  vi_pkg::xlen_t     operand_a_i,
	input  vi_pkg::xlen_t     operand_b_i,
	input  vi_pkg::reg_addr_t rd_i,
	input  vi_pkg::xlen_t     pc_i,
	input  logic              illegal_i,
	output logic              busy_o,
	output vi_pkg::reg_addr_t rd_o,
	vi_result_if.producer     res
);

	vi_pkg::xlen_t result;
	logic [4:0]    shamt;

	assign shamt = operand_b_i[4:0];

	always_comb begin
		case (op_i)
			vi_pkg::ALU_ADD:    result = operand_a_i + operand_b_i;
			vi_pkg::ALU_SUB:    result = operand_a_i - operand_b_i;
			vi_pkg::ALU_SLL:    result = operand_a_i << shamt;
			vi_pkg::ALU_SLT:    result = {31'b0, $signed(operand_a_i) < $signed(operand_b_i)};
			vi_pkg::ALU_SLTU:   result = {31'b0, operand_a_i < operand_b_i};
			vi_pkg::ALU_XOR:    result = operand_a_i ^ operand_b_i;
			vi_pkg::ALU_SRL:    result = operand_a_i >> shamt;
			vi_pkg::ALU_SRA:    result = $unsigned($signed(operand_a_i) >>> shamt);
			vi_pkg::ALU_OR:     result = operand_a_i | operand_b_i;
			vi_pkg::ALU_AND:    result = operand_a_i & operand_b_i;
			vi_pkg::ALU_PASS_B: result = operand_b_i;
			default:            result = '0;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			res.valid   <= 1'b0;
			res.rd      <= '0;
			res.data    <= '0;
			res.pc      <= '0;
			res.illegal <= 1'b0;
		end else begin
			res.valid   <= go_i;
			res.rd      <= rd_i;
			res.data    <= result;
			res.pc      <= pc_i;
			res.illegal <= illegal_i;
		end
	end

	// Occupied stage, seen by the issue hazard check
	assign busy_o = res.valid;
	assign rd_o   = res.rd;

endmodule

//--- source/vi_int_registers.sv
// Integer register file, two combinational read ports and one write port
`timescale 1ns/1ps

module vi_int_registers (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  vi_pkg::reg_addr_t read_addr_a_i,
	input  vi_pkg::reg_addr_t read_addr_b_i,
	output vi_pkg::xlen_t     read_data_a_o,
	output vi_pkg::xlen_t     read_data_b_o,
	input  logic              write_enable_i,
	input  vi_pkg::reg_addr_t write_addr_i,
	input  vi_pkg::xlen_t     write_data_i
);

	// x0 has no storage
	vi_pkg::xlen_t regs [1:31];

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			for (int r = 1; r < 32; r++) begin
				regs[r] <= '0;
			end
		end else if (write_enable_i && (write_addr_i != '0)) begin
			regs[write_addr_i] <= write_data_i;
		end
	end

	assign read_data_a_o = (read_addr_a_i == '0) ? '0 : regs[read_addr_a_i];
	assign read_data_b_o = (read_addr_b_i == '0) ? '0 : regs[read_addr_b_i];

endmodule

//--- source/vi_issue.sv
// Issue stage: decode, operand read, hazard and collision stall, dispatch to ALU or multiply
`timescale 1ns/1ps

module vi_issue #(
	parameter int unsigned MULT_STAGES = vi_pkg::MULT_STAGES_DEFAULT
) (
	input  logic                   issue_valid_i,
	input  vi_pkg::xlen_t          issue_instr_i,
	input  vi_pkg::xlen_t          issue_pc_i,
	output vi_pkg::reg_addr_t      read_addr_a_o,
	output vi_pkg::reg_addr_t      read_addr_b_o,
	input  vi_pkg::xlen_t          read_data_a_i,
	input  vi_pkg::xlen_t          read_data_b_i,
	input  logic                   alu_busy_i,
	input  vi_pkg::reg_addr_t      alu_rd_i,
	input  logic [MULT_STAGES-1:0] mul_busy_i,
	input  vi_pkg::reg_addr_t      mul_rd_i [MULT_STAGES],
	output logic                   issue_stall_o,
	output logic                   alu_go_o,
	output logic                   mul_go_o,
	output vi_pkg::alu_op_e        op_o,
	output vi_pkg::xlen_t          operand_a_o,
	output vi_pkg::xlen_t          operand_b_o,
	output vi_pkg::reg_addr_t      rd_o,
	output vi_pkg::xlen_t          pc_o,
	output logic                   illegal_o
);

	vi_pkg::instr_u instr;
	logic           alu_ok;
	logic           is_mul;
	logic           use_rs1;
	logic           use_rs2;
	logic           use_imm;
	logic           is_lui;
	logic           need_a;
	logic           need_b;
	logic           hazard;
	logic           collision;
	logic           accept;

	assign instr = issue_instr_i;

	always_comb begin
		op_o    = vi_pkg::ALU_ADD;
		alu_ok  = 1'b0;
		is_mul  = 1'b0;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		use_imm = 1'b0;
		is_lui  = 1'b0;
		case (instr.r.opcode)
			vi_pkg::OPC_OP: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				if (instr.r.funct7 == vi_pkg::FUNCT7_MUL) begin
					is_mul = (instr.r.funct3 == 3'b000);
				end else if (instr.r.funct7 == 7'b0) begin
					alu_ok = 1'b1;
					case (instr.r.funct3)
						3'b000: op_o = vi_pkg::ALU_ADD;
						3'b001: op_o = vi_pkg::ALU_SLL;
						3'b010: op_o = vi_pkg::ALU_SLT;
						3'b011: op_o = vi_pkg::ALU_SLTU;
						3'b100: op_o = vi_pkg::ALU_XOR;
						3'b101: op_o = vi_pkg::ALU_SRL;
						3'b110: op_o = vi_pkg::ALU_OR;
						default: op_o = vi_pkg::ALU_AND;
					endcase
				end else if (instr.r.funct7 == vi_pkg::FUNCT7_ALT) begin
					if (instr.r.funct3 == 3'b000) begin
						op_o   = vi_pkg::ALU_SUB;
						alu_ok = 1'b1;
					end else if (instr.r.funct3 == 3'b101) begin
						op_o   = vi_pkg::ALU_SRA;
						alu_ok = 1'b1;
					end
				end
			end
			vi_pkg::OPC_OP_IMM: begin
				use_rs1 = 1'b1;
				use_imm = 1'b1;
				alu_ok  = 1'b1;
				case (instr.i.funct3)
					3'b000: op_o = vi_pkg::ALU_ADD;
					3'b010: op_o = vi_pkg::ALU_SLT;
					3'b011: op_o = vi_pkg::ALU_SLTU;
					3'b100: op_o = vi_pkg::ALU_XOR;
					3'b110: op_o = vi_pkg::ALU_OR;
					3'b111: op_o = vi_pkg::ALU_AND;
					// Shift amounts sit in the rs2 field, upper bits decoded as funct7
					3'b001: begin
						op_o   = vi_pkg::ALU_SLL;
						alu_ok = (instr.r.funct7 == 7'b0);
					end
					default: begin
						op_o   = (instr.r.funct7 == vi_pkg::FUNCT7_ALT) ?
							vi_pkg::ALU_SRA : vi_pkg::ALU_SRL;
						alu_ok = (instr.r.funct7 == 7'b0) ||
							(instr.r.funct7 == vi_pkg::FUNCT7_ALT);
					end
				endcase
			end
			vi_pkg::OPC_LUI: begin
				op_o   = vi_pkg::ALU_PASS_B;
				is_lui = 1'b1;
				alu_ok = 1'b1;
			end
			default: begin
			end
		endcase
	end

	assign read_addr_a_o = instr.r.rs1;
	assign read_addr_b_o = instr.r.rs2;

	assign operand_a_o = read_data_a_i;
	assign operand_b_o = is_lui  ? {instr.i.imm, instr.i.rs1, instr.i.funct3, 12'b0} :
	                     use_imm ? {{20{instr.i.imm[11]}}, instr.i.imm} :
	                               read_data_b_i;

	// Only legal instructions wait for their sources
	assign need_a = use_rs1 && (alu_ok || is_mul) && (instr.r.rs1 != '0);
	assign need_b = use_rs2 && (alu_ok || is_mul) && (instr.r.rs2 != '0);

	always_comb begin
		hazard = alu_busy_i && ((need_a && (instr.r.rs1 == alu_rd_i)) ||
			(need_b && (instr.r.rs2 == alu_rd_i)));
		for (int s = 0; s < MULT_STAGES; s++) begin
			if (mul_busy_i[s] && ((need_a && (instr.r.rs1 == mul_rd_i[s])) ||
				(need_b && (instr.r.rs2 == mul_rd_i[s])))) begin
				hazard = 1'b1;
			end
		end
	end

	// ALU result would meet the multiply leaving its last stage
	assign collision = !is_mul && mul_busy_i[MULT_STAGES-2];

	assign issue_stall_o = issue_valid_i && (hazard || collision);
	assign accept        = issue_valid_i && !issue_stall_o;
	assign alu_go_o      = accept && !is_mul;
	assign mul_go_o      = accept && is_mul;

	assign rd_o      = instr.r.rd;
	assign pc_o      = issue_pc_i;
	assign illegal_o = !(alu_ok || is_mul);

endmodule

//--- source/vi_mult_pipe.sv
// Multiply pipeline of MULT_STAGES stages exposing in-flight destinations
`timescale 1ns/1ps

module vi_mult_pipe #(
	parameter int unsigned MULT_STAGES = vi_pkg::MULT_STAGES_DEFAULT
) (
	input  logic                   clk_i,
	input  logic                   rst_n_i,
	input  logic                   go_i,
	input  vi_pkg::xlen_t          operand_a_i,
	input  vi_pkg::xlen_t          operand_b_i,
	input  vi_pkg::reg_addr_t      rd_i,
	input  vi_pkg::xlen_t          pc_i,
	output logic [MULT_STAGES-1:0] busy_o,
	output vi_pkg::reg_addr_t      rd_o [MULT_STAGES],
	vi_result_if.producer          res
);

	logic [MULT_STAGES-1:0] valid_q;
	vi_pkg::reg_addr_t      rd_q   [MULT_STAGES];
	vi_pkg::xlen_t          data_q [MULT_STAGES];
	vi_pkg::xlen_t          pc_q   [MULT_STAGES];
	vi_pkg::xlen_t          product_lo;

	// Only the low word of the product is kept
	assign product_lo = operand_a_i * operand_b_i;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			valid_q <= '0;
			for (int s = 0; s < MULT_STAGES; s++) begin
				rd_q[s]   <= '0;
				data_q[s] <= '0;
				pc_q[s]   <= '0;
			end
		end else begin
			valid_q[0] <= go_i;
			rd_q[0]    <= rd_i;
			data_q[0]  <= product_lo;
			pc_q[0]    <= pc_i;
			for (int s = 1; s < MULT_STAGES; s++) begin
				valid_q[s] <= valid_q[s-1];
				rd_q[s]    <= rd_q[s-1];
				data_q[s]  <= data_q[s-1];
				pc_q[s]    <= pc_q[s-1];
			end
		end
	end

	assign busy_o = valid_q;
	assign rd_o   = rd_q;

	assign res.valid   = valid_q[MULT_STAGES-1];
	assign res.rd      = rd_q[MULT_STAGES-1];
	assign res.data    = data_q[MULT_STAGES-1];
	assign res.pc      = pc_q[MULT_STAGES-1];
	assign res.illegal = 1'b0;

endmodule

//--- source/vi_pkg.sv
// Data widths, opcodes, funct7 codes, ALU operation enum and instruction word union
package vi_pkg;

	localparam int unsigned XLEN       = 32;
	localparam int unsigned REG_ADDR_W = 5;

	// Default depth of the multiply path
	localparam int unsigned MULT_STAGES_DEFAULT = 5;

	typedef logic [XLEN-1:0]       xlen_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [6:0]            opcode_t;

	localparam opcode_t OPC_OP     = 7'b0110011;
	localparam opcode_t OPC_OP_IMM = 7'b0010011;
	localparam opcode_t OPC_LUI    = 7'b0110111;

	localparam logic [6:0] FUNCT7_MUL = 7'b0000001;
	// Selects sub and sra
	localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B
	} alu_op_e;

	typedef struct packed {
		logic [6:0] funct7;
		reg_addr_t  rs2;
		reg_addr_t  rs1;
		logic [2:0] funct3;
		reg_addr_t  rd;
		opcode_t    opcode;
	} r_type_t;

	typedef struct packed {
		logic [11:0] imm;
		reg_addr_t   rs1;
		logic [2:0]  funct3;
		reg_addr_t   rd;
		opcode_t     opcode;
	} i_type_t;

	// Same 32-bit word seen as register or immediate format
	typedef union packed {
		r_type_t r;
		i_type_t i;
	} instr_u;

endpackage

//--- source/vi_result_if.sv
// Result bundle from an execution path to write-back, with producer and consumer modports
`timescale 1ns/1ps

interface vi_result_if;

	logic              valid;
	vi_pkg::reg_addr_t rd;
	vi_pkg::xlen_t     data;
	vi_pkg::xlen_t     pc;
	logic              illegal;

	modport producer (
		output valid,
		output rd,
		output data,
		output pc,
		output illegal
	);

	modport consumer (
		input valid,
		input rd,
		input data,
		input pc,
		input illegal
	);

endinterface

//--- source/vi_write_back.sv
// Write-back merge of ALU and multiply results into register write and retire report
`timescale 1ns/1ps

module vi_write_back (
	input  logic              clk_i,
	input  logic              rst_n_i,
	vi_result_if.consumer     alu_res,
	vi_result_if.consumer     mul_res,
	output logic              reg_we_o,
	output vi_pkg::reg_addr_t reg_waddr_o,
	output vi_pkg::xlen_t     reg_wdata_o,
	output logic              retire_valid_o,
	output vi_pkg::xlen_t     retire_pc_o,
	output vi_pkg::reg_addr_t retire_rd_o,
	output vi_pkg::xlen_t     retire_data_o,
	output logic              retire_illegal_o
);

	logic          any_valid;
	logic          sel_illegal;
	vi_pkg::xlen_t sel_pc;

	// Issue keeps the two paths from finishing together
	assign any_valid   = alu_res.valid || mul_res.valid;
	assign reg_waddr_o = mul_res.valid ? mul_res.rd      : alu_res.rd;
	assign reg_wdata_o = mul_res.valid ? mul_res.data    : alu_res.data;
	assign sel_illegal = mul_res.valid ? mul_res.illegal : alu_res.illegal;
	assign sel_pc      = mul_res.valid ? mul_res.pc      : alu_res.pc;

	assign reg_we_o = any_valid && !sel_illegal && (reg_waddr_o != '0);

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			retire_valid_o   <= 1'b0;
			retire_pc_o      <= '0;
			retire_rd_o      <= '0;
			retire_data_o    <= '0;
			retire_illegal_o <= 1'b0;
		end else begin
			retire_valid_o   <= any_valid;
			retire_pc_o      <= sel_pc;
			retire_rd_o      <= reg_waddr_o;
			retire_data_o    <= reg_wdata_o;
			retire_illegal_o <= any_valid && sel_illegal;
		end
	end

endmodule

//--- test/tb_vi_exe_core.sv
// Execute core testbench with stimulus table, reference model, retire monitor and watchdog
`timescale 1ns/1ps

module tb_vi_exe_core;

	localparam int unsigned MULT_STAGES = 5;
	localparam int N_TESTS = 45;
	localparam logic [31:0] PC_BASE = 32'h0000_1000;
	localparam int TIMEOUT_NS = N_TESTS * (MULT_STAGES + 6) * 8 * 2 + 5 * 8;

	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] F7_ZERO    = 7'b0000000;
	localparam logic [6:0] F7_ALT     = 7'b0100000;
	localparam logic [6:0] F7_MUL     = 7'b0000001;

	logic        clk_i;
	logic        rst_n_i;
	logic        issue_valid_i;
	logic [31:0] issue_instr_i;
	logic [31:0] issue_pc_i;
	logic        issue_stall_o;
	logic        retire_valid_o;
	logic [31:0] retire_pc_o;
	logic [4:0]  retire_rd_o;
	logic [31:0] retire_data_o;
	logic        retire_illegal_o;

	// Stimulus table with expected values
	logic [31:0] tab_instr   [N_TESTS];
	logic [31:0] tab_pc      [N_TESTS];
	logic        tab_illegal [N_TESTS];
	logic [4:0]  exp_rd      [N_TESTS];
	logic [31:0] exp_data    [N_TESTS];
	logic        exp_mul     [N_TESTS];
	logic [4:0]  src_a       [N_TESTS];
	logic [4:0]  src_b       [N_TESTS];

	int accept_cycle [N_TESTS];
	int retire_cycle [N_TESTS];
	bit retired      [N_TESTS];
	bit test_bad     [N_TESTS];
	int ready_cycle  [32];

	int     n_entries;
	int     cycle;
	int     error_count;
	int     pass_count;
	int     fail_count;
	int     retired_total;
	integer seed;
	int     b2b_first;
	int     ooo_mul;
	int     ooo_alu;

	vi_exe_core #(
		.MULT_STAGES (MULT_STAGES)
	) dut (
		.clk_i            (clk_i),
		.rst_n_i          (rst_n_i),
		.issue_valid_i    (issue_valid_i),
		.issue_instr_i    (issue_instr_i),
		.issue_pc_i       (issue_pc_i),
		.issue_stall_o    (issue_stall_o),
		.retire_valid_o   (retire_valid_o),
		.retire_pc_o      (retire_pc_o),
		.retire_rd_o      (retire_rd_o),
		.retire_data_o    (retire_data_o),
		.retire_illegal_o (retire_illegal_o)
	);

	always #4 clk_i = ~clk_i;

	always @(posedge clk_i) begin
		cycle <= cycle + 1;
	end

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string msg);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s got %h expected %h", $time, msg, got, exp);
			error_count++;
		end
	endtask

	function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2,
		input logic [6:0] opc);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] encode_op_imm(input logic [2:0] f3, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, OPC_OP_IMM};
	endfunction

	function automatic logic [31:0] encode_lui(input logic [4:0] rd, input logic [19:0] imm);
		return {imm, rd, OPC_LUI};
	endfunction

	// RV32I arithmetic for one funct3 with alt selecting sub or arithmetic shift
	function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		logic signed [31:0] sa;
		sa = a;
		case (f3)
			3'b000: return alt ? a - b : a + b;
			3'b001: return a << b[4:0];
			3'b010: return {31'b0, $signed(a) < $signed(b)};
			3'b011: return {31'b0, a < b};
			3'b100: return a ^ b;
			3'b101: begin
				if (alt)
					return sa >>> b[4:0];
				return a >> b[4:0];
			end
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic add_entry(input logic [31:0] word, input logic illegal);
		tab_instr[n_entries]   = word;
		tab_pc[n_entries]      = PC_BASE + 4 * n_entries;
		tab_illegal[n_entries] = illegal;
		n_entries++;
	endtask

	task automatic build_table();
		logic [31:0] rnd;
		rnd = $random(seed);
		add_entry(encode_lui(1, rnd[31:12]), 0);
		add_entry(encode_op_imm(3'b000, 1, 1, rnd[11:0]), 0);
		rnd = $random(seed);
		add_entry(encode_lui(2, rnd[31:12]), 0);
		add_entry(encode_op_imm(3'b000, 2, 2, rnd[11:0]), 0);
		add_entry(encode_lui(3, 20'h80000), 0);
		add_entry(encode_op_imm(3'b000, 4, 0, 12'hFFB), 0);
		add_entry(encode_r(F7_ZERO, 3'b000, 10, 1, 2, OPC_OP), 0);
		add_entry(encode_r(F7_ALT, 3'b000, 11, 1, 2, OPC_OP), 0);
		add_entry(encode_r(F7_ZERO, 3'b001, 12, 1, 2, OPC_OP), 0);
		// Mixed signs so signed and unsigned compares disagree
		add_entry(encode_r(F7_ZERO, 3'b010, 13, 4, 0, OPC_OP), 0);
		add_entry(encode_r(F7_ZERO, 3'b011, 14, 0, 4, OPC_OP), 0);
		add_entry(encode_r(F7_ZERO, 3'b100, 15, 1, 2, OPC_OP), 0);
		add_entry(encode_r(F7_ZERO, 3'b101, 16, 3, 4, OPC_OP), 0);
		add_entry(encode_r(F7_ALT, 3'b101, 17, 3, 4, OPC_OP), 0);
		add_entry(encode_r(F7_ZERO, 3'b110, 18, 1, 2, OPC_OP), 0);
		add_entry(encode_r(F7_ZERO, 3'b111, 19, 1, 2, OPC_OP), 0);
		add_entry(encode_op_imm(3'b010, 20, 4, 12'h001), 0);
		add_entry(encode_op_imm(3'b011, 21, 4, 12'h001), 0);
		add_entry(encode_op_imm(3'b100, 22, 1, 12'h5A5), 0);
		add_entry(encode_op_imm(3'b110, 23, 2, 12'hF0F), 0);
		add_entry(encode_op_imm(3'b111, 24, 1, 12'h7FF), 0);
		add_entry(encode_op_imm(3'b001, 25, 1, {7'b0, 5'd7}), 0);
		add_entry(encode_op_imm(3'b101, 26, 3, {7'b0, 5'd4}), 0);
		add_entry(encode_op_imm(3'b101, 27, 3, {F7_ALT, 5'd4}), 0);
		rnd = $random(seed);
		add_entry(encode_lui(5, rnd[31:12]), 0);
		add_entry(encode_op_imm(3'b000, 5, 5, rnd[11:0]), 0);
		rnd = $random(seed);
		add_entry(encode_lui(6, rnd[31:12]), 0);
		add_entry(encode_op_imm(3'b000, 6, 6, rnd[11:0]), 0);
		b2b_first = n_entries;
		add_entry(encode_r(F7_MUL, 3'b000, 28, 1, 2, OPC_OP), 0);
		add_entry(encode_r(F7_MUL, 3'b000, 29, 5, 6, OPC_OP), 0);
		ooo_mul = n_entries;
		add_entry(encode_r(F7_MUL, 3'b000, 30, 3, 5, OPC_OP), 0);
		ooo_alu = n_entries;
		// Independent ALU work that partly meets a finishing multiply
		add_entry(encode_op_imm(3'b000, 31, 0, 12'h123), 0);
		add_entry(encode_op_imm(3'b110, 20, 0, 12'h456), 0);
		add_entry(encode_op_imm(3'b100, 21, 4, 12'h0F0), 0);
		add_entry(encode_r(F7_MUL, 3'b000, 7, 28, 29, OPC_OP), 0);
		add_entry(encode_r(F7_ZERO, 3'b000, 8, 7, 1, OPC_OP), 0);
		add_entry(encode_r(F7_ALT, 3'b000, 9, 8, 2, OPC_OP), 0);
		add_entry(encode_r(F7_ZERO, 3'b100, 10, 9, 7, OPC_OP), 0);
		add_entry(encode_r(F7_ZERO, 3'b000, 8, 2, 1, 7'b1111011), 1);
		add_entry(encode_op_imm(3'b000, 11, 8, 12'h000), 0);
		add_entry(encode_op_imm(3'b000, 0, 1, 12'h005), 0);
		add_entry(encode_r(F7_ZERO, 3'b000, 12, 0, 1, OPC_OP), 0);
		add_entry(encode_r(7'b0000010, 3'b000, 13, 1, 2, OPC_OP), 1);
		add_entry(encode_r(F7_ZERO, 3'b110, 14, 13, 0, OPC_OP), 0);
		add_entry(encode_r(F7_MUL, 3'b001, 15, 1, 2, OPC_OP), 1);
	endtask

	// Architectural model run in issue order
	task automatic compute_expected();
		logic [31:0] regs_m [32];
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		for (int r = 0; r < 32; r++)
			regs_m[r] = '0;
		for (int i = 0; i < N_TESTS; i++) begin
			w           = tab_instr[i];
			a           = regs_m[w[19:15]];
			b           = regs_m[w[24:20]];
			imm         = {{20{w[31]}}, w[31:20]};
			exp_rd[i]   = w[11:7];
			exp_data[i] = '0;
			exp_mul[i]  = 1'b0;
			src_a[i]    = '0;
			src_b[i]    = '0;
			if (tab_illegal[i]) begin
			end else if (w[6:0] == OPC_LUI) begin
				exp_data[i] = {w[31:12], 12'b0};
			end else if (w[6:0] == OPC_OP_IMM) begin
				exp_data[i] = alu_model(w[14:12], (w[14:12] == 3'b101) && w[30], a, imm);
				src_a[i]    = w[19:15];
			end else begin
				exp_mul[i]  = (w[31:25] == F7_MUL);
				exp_data[i] = exp_mul[i] ? a * b : alu_model(w[14:12], w[30], a, b);
				src_a[i]    = w[19:15];
				src_b[i]    = w[24:20];
			end
			if (!tab_illegal[i] && (w[11:7] != 0))
				regs_m[w[11:7]] = exp_data[i];
		end
	endtask

	task automatic check_sources_ready(input int i);
		if ((src_a[i] != 0 && cycle < ready_cycle[src_a[i]]) ||
			(src_b[i] != 0 && cycle < ready_cycle[src_b[i]])) begin
			$display("instruction %0d was accepted in cycle %0d before its source was written",
				i, cycle);
			error_count++;
			test_bad[i] = 1'b1;
		end
	endtask

	// Retire monitor sampled on the falling edge
	always @(negedge clk_i) begin
		int idx;
		int errs_before;
		int lat;
		if (rst_n_i && retire_valid_o === 1'b1) begin
			idx = (retire_pc_o - PC_BASE) / 4;
			if (retire_pc_o < PC_BASE || idx >= N_TESTS || retire_pc_o[1:0] != 2'b00) begin
				$display("retire of unknown pc %h at %0t ns", retire_pc_o, $time);
				error_count++;
			end else if (retired[idx]) begin
				$display("pc %h retired a second time at %0t ns", retire_pc_o, $time);
				error_count++;
			end else begin
				errs_before       = error_count;
				retired[idx]      = 1'b1;
				retire_cycle[idx] = cycle;
				retired_total++;
				lat = exp_mul[idx] ? MULT_STAGES + 1 : 2;
				check_value(retire_rd_o, exp_rd[idx], "retire rd");
				check_value(retire_illegal_o, tab_illegal[idx], "illegal flag");
				if (!tab_illegal[idx])
					check_value(retire_data_o, exp_data[idx], "retire data");
				check_value(cycle - accept_cycle[idx], lat, "retire latency");
				if (error_count != errs_before)
					test_bad[idx] = 1'b1;
				if (test_bad[idx]) begin
					fail_count++;
					$display("test %0d pc %h failed", idx, tab_pc[idx]);
				end else begin
					pass_count++;
					$display("test %0d pc %h passed", idx, tab_pc[idx]);
				end
			end
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("timeout with %0d of %0d instructions retired, some retires are missing",
			retired_total, N_TESTS);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		int errs_before;
		clk_i         = 1'b0;
		rst_n_i       = 1'b0;
		issue_valid_i = 1'b0;
		issue_instr_i = '0;
		issue_pc_i    = '0;
		cycle         = 0;
		error_count   = 0;
		pass_count    = 0;
		fail_count    = 0;
		retired_total = 0;
		n_entries     = 0;
		seed          = 5227;
		for (int r = 0; r < 32; r++)
			ready_cycle[r] = 0;
		for (int i = 0; i < N_TESTS; i++) begin
			accept_cycle[i] = -1;
			retired[i]      = 1'b0;
			test_bad[i]     = 1'b0;
		end
		build_table();
		compute_expected();

		// First entry waits at the issue port while the pipeline is in reset
		issue_valid_i = 1'b1;
		issue_instr_i = tab_instr[0];
		issue_pc_i    = tab_pc[0];

		errs_before = error_count;
		repeat (5) begin
			@(negedge clk_i);
			check_value(retire_valid_o, 1'b0, "retire valid in reset");
			check_value(issue_stall_o, 1'b0, "stall in reset");
		end
		rst_n_i       = 1'b1;
		issue_valid_i = 1'b0;
		@(negedge clk_i);
		issue_valid_i = 1'b1;
		#1;
		check_value(retire_valid_o, 1'b0, "retire valid when idle");
		check_value(issue_stall_o, 1'b0, "stall when idle");
		if (error_count != errs_before) begin
			fail_count++;
			$display("test reset failed");
		end else begin
			pass_count++;
			$display("test reset passed");
		end

		for (int i = 0; i < N_TESTS; i++) begin
			issue_valid_i = 1'b1;
			issue_instr_i = tab_instr[i];
			issue_pc_i    = tab_pc[i];
			#1;
			while (issue_stall_o) begin
				@(negedge clk_i);
				#1;
			end
			accept_cycle[i] = cycle;
			check_sources_ready(i);
			if (!tab_illegal[i] && exp_rd[i] != 0)
				ready_cycle[exp_rd[i]] = cycle + (exp_mul[i] ? MULT_STAGES + 1 : 2);
			@(negedge clk_i);
		end
		issue_valid_i = 1'b0;

		wait (retired_total == N_TESTS);
		// A few more cycles to catch duplicate retires
		repeat (3) @(negedge clk_i);

		errs_before = error_count;
		check_value(accept_cycle[b2b_first + 1] - accept_cycle[b2b_first], 1,
			"back-to-back multiply accept distance");
		check_value(retire_cycle[ooo_alu] < retire_cycle[ooo_mul], 1,
			"ALU retire ahead of earlier multiply");
		if (error_count != errs_before) begin
			fail_count++;
			$display("test ordering failed");
		end else begin
			pass_count++;
			$display("test ordering passed");
		end

		$display("tests passed %0d failed %0d errors %0d", pass_count, fail_count, error_count);
		if (error_count == 0 && fail_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule
